// File: verilog/fpu32_config.svh
/* Width, conversion latency and counter width macros for the scalar FPU */
`ifndef FPU32_CONFIG_SVH
`define FPU32_CONFIG_SVH

// ==================================================
// Datapath
// ==================================================

// Operand and result width of the unit
`define FPU_WID 32

// ==================================================
// Timing
// ==================================================

// Clock edges from an argument change until a conversion result is valid
// The conversion pipeline in the floating unit is this many registers deep
`define FPU_CVT_LAT 2

// Width of the latency counter in the result stage
`define FPU_CNT_WID 4

`endif

// File: verilog/fpu32_pkg.sv
/* Opcode, integer function, float function and result unit enums */
package fpu32_pkg;

	// Primary opcode held in instruction bits 6 to 0
	typedef enum logic [6:0] {
		OP_R2    = 7'h02,
		OP_ADDI  = 7'h04,
		OP_MOV   = 7'h07,
		OP_ANDI  = 7'h08,
		OP_ORI   = 7'h09,
		OP_EORI  = 7'h0A,
		OP_CMPI  = 7'h0B,
		OP_CMPUI = 7'h0C,
		OP_FLT   = 7'h0D,
		OP_NOP   = 7'h3F
	} opcode_e;

	// Function field in bits 31 to 26 under OP_R2
	typedef enum logic [5:0] {
		FN_ADD    = 6'h04,
		FN_SUB    = 6'h05,
		FN_AND    = 6'h08,
		FN_OR     = 6'h09,
		FN_EOR    = 6'h0A,
		FN_CMP    = 6'h0B,
		FN_CMPU   = 6'h0C,
		FN_CMOVZ  = 6'h10,
		FN_CMOVNZ = 6'h11,
		FN_MOV    = 6'h14
	} int_func_e;

	// Function field in bits 31 to 26 under OP_FLT
	typedef enum logic [5:0] {
		FN_FABS   = 6'h01,
		FN_FNEG   = 6'h02,
		FN_FSGNJ  = 6'h04,
		FN_FSGNJN = 6'h05,
		FN_FSGNJX = 6'h06,
		FN_FSEQ   = 6'h08,
		FN_FSLT   = 6'h09,
		FN_FSLE   = 6'h0A,
		FN_FCMP   = 6'h0B,
		FN_ISNAN  = 6'h0C,
		FN_FINITE = 6'h0D,
		FN_FTOI   = 6'h10,
		FN_ITOF   = 6'h11
	} flt_func_e;

	// Which execute unit feeds the result bus
	typedef enum logic [1:0] {
		UNIT_NONE = 2'd0,
		UNIT_INT  = 2'd1,
		UNIT_FP   = 2'd2
	} unit_e;

endpackage

// File: verilog/fpu32_decode.sv
/* Instruction decode mapping opcodes and functions onto an execute unit,
   a function, the operand source and the operation latency */
`timescale 1ns/1ps
`include "fpu32_config.svh"

module fpu32_decode (
	input  logic [`FPU_WID-1:0]  ir,
	output fpu32_pkg::unit_e     unit,
	output fpu32_pkg::int_func_e int_func,
	output fpu32_pkg::flt_func_e flt_func,
	output logic [2:0]           op2,
	output logic                 use_imm,
	output logic                 multi
);

	fpu32_pkg::opcode_e      opcode;
	fpu32_pkg::int_func_e    r2_func;
	fpu32_pkg::flt_func_e    fp_func;
	logic [`FPU_CNT_WID-1:0] lat;

	// Static casts keep undefined encodings, the case below rejects them
	assign opcode  = fpu32_pkg::opcode_e'(ir[6:0]);
	assign r2_func = fpu32_pkg::int_func_e'(ir[31:26]);
	assign fp_func = fpu32_pkg::flt_func_e'(ir[31:26]);

	always_comb begin
		unit     = fpu32_pkg::UNIT_NONE;
		int_func = r2_func;
		flt_func = fp_func;
		op2      = ir[25:23];
		use_imm  = 1'b0;
		lat      = '0;
		case (opcode)
			fpu32_pkg::OP_R2: begin
				case (r2_func)
					fpu32_pkg::FN_ADD, fpu32_pkg::FN_SUB, fpu32_pkg::FN_AND,
					fpu32_pkg::FN_OR, fpu32_pkg::FN_EOR, fpu32_pkg::FN_CMP,
					fpu32_pkg::FN_CMPU, fpu32_pkg::FN_CMOVZ, fpu32_pkg::FN_CMOVNZ,
					fpu32_pkg::FN_MOV:
						unit = fpu32_pkg::UNIT_INT;
					default:
						unit = fpu32_pkg::UNIT_NONE;
				endcase
			end
			fpu32_pkg::OP_FLT: begin
				case (fp_func)
					// Only the conversions take the pipelined path
					fpu32_pkg::FN_FTOI, fpu32_pkg::FN_ITOF: begin
						unit = fpu32_pkg::UNIT_FP;
						lat  = `FPU_CNT_WID'(`FPU_CVT_LAT);
					end
					fpu32_pkg::FN_FABS, fpu32_pkg::FN_FNEG, fpu32_pkg::FN_FSGNJ,
					fpu32_pkg::FN_FSGNJN, fpu32_pkg::FN_FSGNJX, fpu32_pkg::FN_FSEQ,
					fpu32_pkg::FN_FSLT, fpu32_pkg::FN_FSLE, fpu32_pkg::FN_FCMP,
					fpu32_pkg::FN_ISNAN, fpu32_pkg::FN_FINITE:
						unit = fpu32_pkg::UNIT_FP;
					default:
						unit = fpu32_pkg::UNIT_NONE;
				endcase
			end
			// Immediate logic and add forms skip the combine with c
			fpu32_pkg::OP_ADDI, fpu32_pkg::OP_ANDI, fpu32_pkg::OP_ORI,
			fpu32_pkg::OP_EORI: begin
				unit    = fpu32_pkg::UNIT_INT;
				op2     = 3'd7;
				use_imm = 1'b1;
				case (opcode)
					fpu32_pkg::OP_ANDI: int_func = fpu32_pkg::FN_AND;
					fpu32_pkg::OP_ORI:  int_func = fpu32_pkg::FN_OR;
					fpu32_pkg::OP_EORI: int_func = fpu32_pkg::FN_EOR;
					default:            int_func = fpu32_pkg::FN_ADD;
				endcase
			end
			// Immediate compares AND their flags with c
			fpu32_pkg::OP_CMPI, fpu32_pkg::OP_CMPUI: begin
				unit     = fpu32_pkg::UNIT_INT;
				op2      = 3'd0;
				use_imm  = 1'b1;
				int_func = (opcode == fpu32_pkg::OP_CMPUI) ? fpu32_pkg::FN_CMPU
					: fpu32_pkg::FN_CMP;
			end
			fpu32_pkg::OP_MOV: begin
				unit     = fpu32_pkg::UNIT_INT;
				int_func = fpu32_pkg::FN_MOV;
				op2      = 3'd7;
			end
			// NOP and unknown opcodes leave the result bus at zero
			default: ;
		endcase
	end

	assign multi = (lat != '0);

endmodule

// File: verilog/fpu32_int_exec.sv
/* Combinational integer execute unit with two-input operations, the combine
   with c, signed and unsigned compare and the conditional moves */
`timescale 1ns/1ps
`include "fpu32_config.svh"

module fpu32_int_exec (
	input  fpu32_pkg::int_func_e int_func,
	input  logic [2:0]           op2,
	input  logic                 use_imm,
	input  logic [`FPU_WID-1:0]  a,
	input  logic [`FPU_WID-1:0]  b,
	input  logic [`FPU_WID-1:0]  c,
	input  logic [`FPU_WID-1:0]  i,
	output logic [`FPU_WID-1:0]  int_res
);

	logic [`FPU_WID-1:0] opb;
	logic [`FPU_WID-1:0] base;
	logic [2:0]          cmp_bits;
	logic                combine;

	// Immediate forms replace b with i
	assign opb = use_imm ? i : b;

	// ==================================================
	// Compare flags, bit 0 equal, bit 1 less, bit 2 less or equal
	// ==================================================
	always_comb begin
		cmp_bits[0] = (a == opb);
		if (int_func == fpu32_pkg::FN_CMPU) begin
			cmp_bits[1] = (a < opb);
			cmp_bits[2] = (a <= opb);
		end else begin
			cmp_bits[1] = ($signed(a) < $signed(opb));
			cmp_bits[2] = ($signed(a) <= $signed(opb));
		end
	end

	// ==================================================
	// Two-input result before the combine stage
	// ==================================================
	always_comb begin
		combine = 1'b1;
		case (int_func)
			fpu32_pkg::FN_ADD:  base = a + opb;
			fpu32_pkg::FN_AND:  base = a & opb;
			fpu32_pkg::FN_OR:   base = a | opb;
			fpu32_pkg::FN_EOR:  base = a ^ opb;
			fpu32_pkg::FN_CMP, fpu32_pkg::FN_CMPU:
				base = {{(`FPU_WID-3){1'b0}}, cmp_bits};
			// Subtract always takes c as a third operand
			fpu32_pkg::FN_SUB: begin
				base    = a - opb - c;
				combine = 1'b0;
			end
			fpu32_pkg::FN_CMOVZ: begin
				base    = (a != '0) ? c : b;
				combine = 1'b0;
			end
			fpu32_pkg::FN_CMOVNZ: begin
				base    = (a != '0) ? b : c;
				combine = 1'b0;
			end
			fpu32_pkg::FN_MOV: begin
				base    = a;
				combine = 1'b0;
			end
			default: begin
				base    = '0;
				combine = 1'b0;
			end
		endcase
	end

	// op2 folds c into the two-input result
	// Add c exists only for FN_ADD, other selectors give zero
	always_comb begin
		if (!combine)
			int_res = base;
		else begin
			case (op2)
				3'd0:    int_res = base & c;
				3'd1:    int_res = base | c;
				3'd2:    int_res = base ^ c;
				3'd3:    int_res = (int_func == fpu32_pkg::FN_ADD) ? base + c : '0;
				3'd7:    int_res = base;
				default: int_res = '0;
			endcase
		end
	end

endmodule

// File: verilog/fpu32_fp_exec.sv
/* Single-precision execute unit with sign, classify and compare paths and
   the pipelined float to integer and integer to float conversions */
`timescale 1ns/1ps
`include "fpu32_config.svh"

module fpu32_fp_exec (
	input  logic                 clk,
	input  logic                 rst,
	input  fpu32_pkg::flt_func_e flt_func,
	input  logic [`FPU_WID-1:0]  a,
	input  logic [`FPU_WID-1:0]  b,
	output logic [`FPU_WID-1:0]  fp_res
);

	logic                a_nan;
	logic                b_nan;
	logic                both_zero;
	logic [2:0]          cmp_bits;
	logic [30:0]         f2i_mag;
	logic [`FPU_WID-1:0] f2i_d;
	logic [`FPU_WID-1:0] i2f_abs;
	logic [`FPU_WID-1:0] i2f_norm;
	logic [4:0]          i2f_lz;
	logic                i2f_rnd;
	logic [30:0]         i2f_pack;
	logic [`FPU_WID-1:0] i2f_d;
	logic [`FPU_WID-1:0] f2i_q [`FPU_CVT_LAT];
	logic [`FPU_WID-1:0] i2f_q [`FPU_CVT_LAT];

	assign a_nan     = (&a[30:23]) & (|a[22:0]);
	assign b_nan     = (&b[30:23]) & (|b[22:0]);
	assign both_zero = (a[30:0] == '0) & (b[30:0] == '0);

	// ==================================================
	// Compare with +0 equal to -0 and NaN unordered
	// ==================================================
	always_comb begin
		cmp_bits[0] = both_zero | (a == b);
		if (both_zero)
			cmp_bits[1] = 1'b0;
		else if (a[31] != b[31])
			cmp_bits[1] = a[31];
		// Negative magnitudes order backwards
		else if (a[31])
			cmp_bits[1] = (a[30:0] > b[30:0]);
		else
			cmp_bits[1] = (a[30:0] < b[30:0]);
		cmp_bits[2] = cmp_bits[0] | cmp_bits[1];
		if (a_nan | b_nan)
			cmp_bits = 3'b000;
	end

	// ==================================================
	// Float to signed integer, truncating toward zero
	// ==================================================
	always_comb begin
		// Exponent 157 leaves the hidden bit at bit 30 of the magnitude
		f2i_mag = {1'b1, a[22:0], 7'd0} >> (8'd157 - a[30:23]);
		if (a_nan)
			f2i_d = 32'h7FFF_FFFF;
		else if (a[30:23] < 8'd127)
			f2i_d = '0;
		else if (a[30:23] > 8'd157)
			f2i_d = a[31] ? 32'h8000_0000 : 32'h7FFF_FFFF;
		else
			f2i_d = a[31] ? -{1'b0, f2i_mag} : {1'b0, f2i_mag};
	end

	// ==================================================
	// Signed integer to float, round to nearest even
	// ==================================================
	always_comb begin
		i2f_abs = a[31] ? -a : a;
		i2f_lz  = '0;
		// Last set bit seen is the leading one
		for (int k = 0; k < `FPU_WID; k++) begin
			if (i2f_abs[k])
				i2f_lz = 5'(31 - k);
		end
		i2f_norm = i2f_abs << i2f_lz;
		// Guard bit with sticky or an odd lsb rounds up
		i2f_rnd  = i2f_norm[7] & ((|i2f_norm[6:0]) | i2f_norm[8]);
		// A mantissa carry ripples into the exponent
		i2f_pack = {8'd158 - {3'd0, i2f_lz}, i2f_norm[30:8]} + {30'd0, i2f_rnd};
		if (i2f_abs == '0)
			i2f_d = '0;
		else
			i2f_d = {a[31], i2f_pack};
	end

	// Conversion results move one stage per clock
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int s = 0; s < `FPU_CVT_LAT; s++) begin
				f2i_q[s] <= '0;
				i2f_q[s] <= '0;
			end
		end else begin
			f2i_q[0] <= f2i_d;
			i2f_q[0] <= i2f_d;
			for (int s = 1; s < `FPU_CVT_LAT; s++) begin
				f2i_q[s] <= f2i_q[s-1];
				i2f_q[s] <= i2f_q[s-1];
			end
		end
	end

	always_comb begin
		case (flt_func)
			fpu32_pkg::FN_FABS:   fp_res = {1'b0, a[30:0]};
			fpu32_pkg::FN_FNEG:   fp_res = {~a[31], a[30:0]};
			fpu32_pkg::FN_FSGNJ:  fp_res = {a[31], b[30:0]};
			fpu32_pkg::FN_FSGNJN: fp_res = {~a[31], b[30:0]};
			fpu32_pkg::FN_FSGNJX: fp_res = {a[31] ^ b[31], b[30:0]};
			fpu32_pkg::FN_FSEQ:   fp_res = {{(`FPU_WID-1){1'b0}}, cmp_bits[0]};
			fpu32_pkg::FN_FSLT:   fp_res = {{(`FPU_WID-1){1'b0}}, cmp_bits[1]};
			fpu32_pkg::FN_FSLE:   fp_res = {{(`FPU_WID-1){1'b0}}, cmp_bits[2]};
			fpu32_pkg::FN_FCMP:   fp_res = {{(`FPU_WID-3){1'b0}}, cmp_bits};
			fpu32_pkg::FN_ISNAN:  fp_res = {{(`FPU_WID-1){1'b0}}, a_nan};
			fpu32_pkg::FN_FINITE: fp_res = {{(`FPU_WID-1){1'b0}}, ~&a[30:23]};
			fpu32_pkg::FN_FTOI:   fp_res = f2i_q[`FPU_CVT_LAT-1];
			fpu32_pkg::FN_ITOF:   fp_res = i2f_q[`FPU_CVT_LAT-1];
			default:              fp_res = '0;
		endcase
	end

endmodule

// File: verilog/fpu32_result.sv
/* Argument change detector, saturating latency counter, done level and
   result bus select */
`timescale 1ns/1ps
`include "fpu32_config.svh"

module fpu32_result (
	input  logic                clk,
	input  logic                rst,
	input  logic [`FPU_WID-1:0] ir,
	input  logic [`FPU_WID-1:0] a,
	input  logic [`FPU_WID-1:0] b,
	input  fpu32_pkg::unit_e    unit,
	input  logic                multi,
	input  logic [`FPU_WID-1:0] int_res,
	input  logic [`FPU_WID-1:0] fp_res,
	output logic [`FPU_WID-1:0] o,
	output logic                done
);

	logic [3*`FPU_WID-1:0]   arg_q;
	logic                    arg_change;
	logic [`FPU_CNT_WID-1:0] cnt;

	// Any difference from last cycle's arguments restarts the timing
	assign arg_change = ({ir, a, b} != arg_q);

	// ==================================================
	// Latency counter
	// ==================================================
	// A count of k means k+1 edges have passed since the last change
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			arg_q <= '0;
			cnt   <= '0;
		end else begin
			arg_q <= {ir, a, b};
			if (arg_change)
				cnt <= '0;
			else if (cnt != '1)
				cnt <= cnt + 1'b1;
		end
	end

	// Single-cycle operations are always done
	// Conversions wait for the pipeline depth after the last change
	assign done = ~multi | (~arg_change & (cnt >= `FPU_CNT_WID'(`FPU_CVT_LAT - 1)));

	always_comb begin
		case (unit)
			fpu32_pkg::UNIT_INT: o = int_res;
			fpu32_pkg::UNIT_FP:  o = fp_res;
			default:             o = '0;
		endcase
	end

endmodule

// File: verilog/fpu32_unit.sv
/* Scalar functional unit top joining decode, both execute units and the
   result stage */
`timescale 1ns/1ps
`include "fpu32_config.svh"

module fpu32_unit (
	input  logic                clk,
	input  logic                rst,
	input  logic [`FPU_WID-1:0] ir,
	input  logic [`FPU_WID-1:0] a,
	input  logic [`FPU_WID-1:0] b,
	input  logic [`FPU_WID-1:0] c,
	input  logic [`FPU_WID-1:0] i,
	output logic [`FPU_WID-1:0] o,
	output logic                done
);

	fpu32_pkg::unit_e     unit;
	fpu32_pkg::int_func_e int_func;
	fpu32_pkg::flt_func_e flt_func;
	logic [2:0]           op2;
	logic                 use_imm;
	logic                 multi;
	logic [`FPU_WID-1:0]  int_res;
	logic [`FPU_WID-1:0]  fp_res;

	fpu32_decode i_decode (
		.ir(ir), .unit(unit), .int_func(int_func), .flt_func(flt_func),
		.op2(op2), .use_imm(use_imm), .multi(multi)
	);

	fpu32_int_exec i_int_exec (
		.int_func(int_func), .op2(op2), .use_imm(use_imm),
		.a(a), .b(b), .c(c), .i(i), .int_res(int_res)
	);

	// Conversions are clocked, the rest of the floating unit is not
	fpu32_fp_exec i_fp_exec (
		.clk(clk), .rst(rst), .flt_func(flt_func), .a(a), .b(b), .fp_res(fp_res)
	);

	fpu32_result i_result (
		.clk(clk), .rst(rst), .ir(ir), .a(a), .b(b), .unit(unit), .multi(multi),
		.int_res(int_res), .fp_res(fp_res), .o(o), .done(done)
	);

endmodule

// File: dv/fpu32_checker.sv
/* Bound checker with concurrent assertions on done around reset and conversions */
`timescale 1ns/1ps
`include "fpu32_config.svh"

module fpu32_checker (
	input logic                clk,
	input logic                rst,
	input logic [`FPU_WID-1:0] ir,
	input logic [`FPU_WID-1:0] a,
	input logic [`FPU_WID-1:0] b,
	input logic                multi,
	input logic                done
);

	logic [3*`FPU_WID-1:0] args_q;
	logic                  chg;
	int                    fail_cnt;

	initial fail_cnt = 0;

	// Last cycle's arguments, so chg is high in the cycle of an input change
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			args_q <= '0;
		else
			args_q <= {ir, a, b};
	end

	assign chg = ({ir, a, b} != args_q);

	// ==================================================
	// Done behavior
	// ==================================================
	// Reset leaves the unit idle on a single-cycle encoding
	reset_done: assert property (@(posedge clk) rst |-> done)
		else begin
			$error("done low while reset is held");
			fail_cnt++;
		end

	// A conversion never reports done in the cycle its inputs move
	change_low: assert property (@(posedge clk) disable iff (rst) (multi && chg) |-> !done)
		else begin
			$error("done high in the cycle of a conversion input change");
			fail_cnt++;
		end

	// With a latency of two the cycle after the change is still busy
	min_latency: assert property (@(posedge clk) disable iff (rst)
		(multi && chg) ##1 (multi && !chg) |-> !done)
		else begin
			$error("done high before the conversion latency elapsed");
			fail_cnt++;
		end

endmodule

// File: dv/fpu32_tb.sv
/* Testbench for the scalar unit with LFSR stimulus, a reference model,
   immediate assertions and per-test reporting */
`timescale 1ns/1ps
`include "fpu32_config.svh"

module fpu32_tb;

	logic                clk;
	logic                rst;
	logic [`FPU_WID-1:0] ir;
	logic [`FPU_WID-1:0] a;
	logic [`FPU_WID-1:0] b;
	logic [`FPU_WID-1:0] c;
	logic [`FPU_WID-1:0] i;
	logic [`FPU_WID-1:0] o;
	logic                done;
	logic [15:0]         lfsr;
	int                  test_fail;
	int                  tests_ok;
	int                  tests_bad;
	logic [31:0]         specials [8];

	fpu32_unit i_fpu32_unit (
		.clk(clk), .rst(rst), .ir(ir), .a(a), .b(b), .c(c), .i(i), .o(o), .done(done)
	);

	bind fpu32_unit fpu32_checker i_checker (
		.clk(clk), .rst(rst), .ir(ir), .a(a), .b(b), .multi(multi), .done(done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Galois LFSR stepped once for each bit taken
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [31:0] enc(logic [6:0] opc, logic [5:0] fn, logic [2:0] sel);
		return {fn, sel, 16'd0, opc};
	endfunction

	// ==================================================
	// Reference model
	// ==================================================
	// Maps a float onto an unsigned key with the same order and one key for both zeros
	function automatic logic [31:0] order_key(logic [31:0] f);
		if (f[30:0] == 31'd0)
			return 32'h8000_0000;
		return f[31] ? ~f : (f | 32'h8000_0000);
	endfunction

	function automatic logic [31:0] ftoi_model(logic [31:0] f);
		logic [7:0]  e;
		logic [63:0] m;
		logic [63:0] v;
		e = f[30:23];
		if (e == 8'hFF && f[22:0] != 23'd0)
			return 32'h7FFF_FFFF;
		if (e < 8'd127)
			return 32'd0;
		if (e >= 8'd158)
			return f[31] ? 32'h8000_0000 : 32'h7FFF_FFFF;
		m = {40'd0, 1'b1, f[22:0]};
		if (e >= 8'd150)
			v = m << (e - 8'd150);
		else
			v = m >> (8'd150 - e);
		return f[31] ? (~v[31:0] + 32'd1) : v[31:0];
	endfunction

	function automatic logic [31:0] itof_model(logic [31:0] x);
		logic [31:0] mag;
		logic [63:0] m;
		logic [63:0] rem;
		logic [63:0] half;
		int          e;
		int          sh;
		if (x == 32'd0)
			return 32'd0;
		mag = x[31] ? (~x + 32'd1) : x;
		e = 31;
		while (!mag[e])
			e--;
		if (e <= 23) begin
			m = {32'd0, mag} << (23 - e);
		end else begin
			sh   = e - 23;
			m    = {32'd0, mag} >> sh;
			rem  = {32'd0, mag} & ((64'd1 << sh) - 64'd1);
			half = 64'd1 << (sh - 1);
			// Ties go to the even mantissa
			if (rem > half || (rem == half && m[0]))
				m = m + 64'd1;
			if (m[24]) begin
				m = m >> 1;
				e++;
			end
		end
		return {x[31], 8'(e + 127), m[22:0]};
	endfunction

	function automatic logic [31:0] fp_model(logic [5:0] fn, logic [31:0] x, logic [31:0] y);
		logic xn;
		logic yn;
		logic eq;
		logic lt;
		xn = (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
		yn = (y[30:23] == 8'hFF) && (y[22:0] != 23'd0);
		eq = !xn && !yn && (order_key(x) == order_key(y));
		lt = !xn && !yn && (order_key(x) < order_key(y));
		case (fn)
			fpu32_pkg::FN_FABS:   return {1'b0, x[30:0]};
			fpu32_pkg::FN_FNEG:   return {~x[31], x[30:0]};
			fpu32_pkg::FN_FSGNJ:  return {x[31], y[30:0]};
			fpu32_pkg::FN_FSGNJN: return {~x[31], y[30:0]};
			fpu32_pkg::FN_FSGNJX: return {x[31] ^ y[31], y[30:0]};
			fpu32_pkg::FN_FSEQ:   return {31'd0, eq};
			fpu32_pkg::FN_FSLT:   return {31'd0, lt};
			fpu32_pkg::FN_FSLE:   return {31'd0, eq | lt};
			fpu32_pkg::FN_FCMP:   return {29'd0, eq | lt, lt, eq};
			fpu32_pkg::FN_ISNAN:  return {31'd0, xn};
			fpu32_pkg::FN_FINITE: return {31'd0, x[30:23] != 8'hFF};
			fpu32_pkg::FN_FTOI:   return ftoi_model(x);
			fpu32_pkg::FN_ITOF:   return itof_model(x);
			default:              return 32'd0;
		endcase
	endfunction

	// y is the second operand after the immediate choice
	function automatic logic [31:0] int_model(logic [5:0] fn, logic [2:0] sel,
		logic [31:0] x, logic [31:0] y, logic [31:0] z);
		logic [31:0] r;
		case (fn)
			fpu32_pkg::FN_ADD:    r = x + y;
			fpu32_pkg::FN_AND:    r = x & y;
			fpu32_pkg::FN_OR:     r = x | y;
			fpu32_pkg::FN_EOR:    r = x ^ y;
			fpu32_pkg::FN_CMP:
				r = {29'd0, $signed(x) <= $signed(y), $signed(x) < $signed(y), x == y};
			fpu32_pkg::FN_CMPU:   r = {29'd0, x <= y, x < y, x == y};
			fpu32_pkg::FN_SUB:    return x - y - z;
			fpu32_pkg::FN_CMOVZ:  return (x == 32'd0) ? y : z;
			fpu32_pkg::FN_CMOVNZ: return (x == 32'd0) ? z : y;
			fpu32_pkg::FN_MOV:    return x;
			default:              return 32'd0;
		endcase
		case (sel)
			3'd0:    return r & z;
			3'd1:    return r | z;
			3'd2:    return r ^ z;
			3'd3:    return (fn == fpu32_pkg::FN_ADD) ? r + z : 32'd0;
			3'd7:    return r;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] unit_model(logic [31:0] w, logic [31:0] x,
		logic [31:0] y, logic [31:0] z, logic [31:0] imm);
		logic [5:0] fn;
		logic [2:0] sel;
		logic [31:0] opb;
		fn  = w[31:26];
		sel = w[25:23];
		opb = y;
		case (w[6:0])
			fpu32_pkg::OP_R2:    ;
			fpu32_pkg::OP_FLT:   return fp_model(fn, x, y);
			fpu32_pkg::OP_MOV:   return x;
			fpu32_pkg::OP_ADDI:  fn = fpu32_pkg::FN_ADD;
			fpu32_pkg::OP_ANDI:  fn = fpu32_pkg::FN_AND;
			fpu32_pkg::OP_ORI:   fn = fpu32_pkg::FN_OR;
			fpu32_pkg::OP_EORI:  fn = fpu32_pkg::FN_EOR;
			fpu32_pkg::OP_CMPI:  fn = fpu32_pkg::FN_CMP;
			fpu32_pkg::OP_CMPUI: fn = fpu32_pkg::FN_CMPU;
			default:             return 32'd0;
		endcase
		// Immediate forms take i as the second operand and only the compares AND with c
		if (w[6:0] != fpu32_pkg::OP_R2) begin
			opb = imm;
			sel = (fn == fpu32_pkg::FN_CMP || fn == fpu32_pkg::FN_CMPU) ? 3'd0 : 3'd7;
		end
		return int_model(fn, sel, x, opb, z);
	endfunction

	// ==================================================
	// Drive, wait and check
	// ==================================================
	// Called on a falling edge and returns on the falling edge where done was seen
	task automatic run_op(input string name, input logic [31:0] w, input logic [31:0] x,
		input logic [31:0] y, input logic [31:0] z, input logic [31:0] imm);
		logic [31:0] expected;
		logic        conv;
		logic        fresh;
		int          cycles;
		expected = unit_model(w, x, y, z, imm);
		conv  = (w[6:0] == fpu32_pkg::OP_FLT) &&
			(w[31:26] == fpu32_pkg::FN_FTOI || w[31:26] == fpu32_pkg::FN_ITOF);
		fresh = ({w, x, y} != {ir, a, b});
		ir = w;
		a  = x;
		b  = y;
		c  = z;
		i  = imm;
		cycles = 1;
		@(negedge clk);
		while (!done && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			$display("Timeout: done never rose for %s", name);
			$display("TB FAILED");
			$finish;
		end else begin
			assert (o === expected)
			else begin
				$display("ERROR %0t: %s gave %h, expected %h", $time, name, o, expected);
				test_fail++;
			end
			// A conversion started on new inputs takes exactly the pipeline depth
			if (conv && fresh) begin
				assert (cycles == `FPU_CVT_LAT)
				else begin
					$display("ERROR %0t: %s done after %0d cycles", $time, name, cycles);
					test_fail++;
				end
			end else if (!conv) begin
				// Single-cycle operations already show done at the first falling edge
				assert (cycles == 1)
				else begin
					$display("ERROR %0t: %s done after %0d cycles", $time, name, cycles);
					test_fail++;
				end
			end
		end
	endtask

	task automatic close_test(input string name);
		if (test_fail == 0) begin
			$display("test %s: ok", name);
			tests_ok++;
		end else begin
			$display("test %s: %0d mismatches", name, test_fail);
			tests_bad++;
		end
		test_fail = 0;
	endtask

	initial begin
		logic [5:0] fns [4];
		logic [2:0] sels [5];
		logic [5:0] sgn_fns [7];
		logic [5:0] cmp_fns [4];
		logic [31:0] x;
		logic [31:0] y;
		int          chk_fails;
		fns      = '{fpu32_pkg::FN_ADD, fpu32_pkg::FN_AND, fpu32_pkg::FN_OR, fpu32_pkg::FN_EOR};
		sels     = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd7};
		sgn_fns  = '{fpu32_pkg::FN_FABS, fpu32_pkg::FN_FNEG, fpu32_pkg::FN_FSGNJ,
			fpu32_pkg::FN_FSGNJN, fpu32_pkg::FN_FSGNJX, fpu32_pkg::FN_ISNAN,
			fpu32_pkg::FN_FINITE};
		cmp_fns  = '{fpu32_pkg::FN_FSEQ, fpu32_pkg::FN_FSLT, fpu32_pkg::FN_FSLE,
			fpu32_pkg::FN_FCMP};
		// Quiet NaN, signalling NaN, both infinities, both zeros, one, minus two
		specials = '{32'h7FC0_0000, 32'h7F80_0001, 32'h7F80_0000, 32'hFF80_0000,
			32'h0000_0000, 32'h8000_0000, 32'h3F80_0000, 32'hC000_0000};
		lfsr      = 16'd49666;
		test_fail = 0;
		tests_ok  = 0;
		tests_bad = 0;
		rst = 1'b1;
		ir  = '0;
		a   = '0;
		b   = '0;
		c   = '0;
		i   = '0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// Two-input forms under every combine, subtract and the immediates
		for (int f = 0; f < 4; f++)
			for (int s = 0; s < 5; s++)
				run_op("r2", enc(fpu32_pkg::OP_R2, fns[f], sels[s]),
					rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32));
		for (int n = 0; n < 4; n++) begin
			run_op("sub", enc(fpu32_pkg::OP_R2, fpu32_pkg::FN_SUB, 3'd7),
				rand_bits(32), rand_bits(32), rand_bits(32), 32'd0);
			run_op("addi", enc(fpu32_pkg::OP_ADDI, 6'd0, 3'd0),
				rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32));
			run_op("andi", enc(fpu32_pkg::OP_ANDI, 6'd0, 3'd0),
				rand_bits(32), 32'd0, 32'd0, rand_bits(32));
			run_op("ori", enc(fpu32_pkg::OP_ORI, 6'd0, 3'd0),
				rand_bits(32), 32'd0, 32'd0, rand_bits(32));
			run_op("eori", enc(fpu32_pkg::OP_EORI, 6'd0, 3'd0),
				rand_bits(32), 32'd0, 32'd0, rand_bits(32));
			run_op("mov", enc(fpu32_pkg::OP_MOV, 6'd0, 3'd0),
				rand_bits(32), rand_bits(32), 32'd0, 32'd0);
		end
		close_test("integer_forms");

		// Equal operands, differing signs and random pairs
		for (int n = 0; n < 6; n++) begin
			x = rand_bits(32);
			y = (n < 2) ? x : ((n < 4) ? (x ^ 32'h8000_0000) : rand_bits(32));
			for (int s = 0; s < 5; s++) begin
				run_op("cmp", enc(fpu32_pkg::OP_R2, fpu32_pkg::FN_CMP, sels[s]),
					x, y, 32'h7, 32'd0);
				run_op("cmpu", enc(fpu32_pkg::OP_R2, fpu32_pkg::FN_CMPU, sels[s]),
					x, y, rand_bits(3), 32'd0);
			end
			run_op("cmpi", enc(fpu32_pkg::OP_CMPI, 6'd0, 3'd0), x, 32'd0, 32'h7, y);
			run_op("cmpui", enc(fpu32_pkg::OP_CMPUI, 6'd0, 3'd0), x, 32'd0, 32'h5, y);
			run_op("cmovz", enc(fpu32_pkg::OP_R2, fpu32_pkg::FN_CMOVZ, 3'd7),
				(n < 3) ? 32'd0 : x, y, rand_bits(32), 32'd0);
			run_op("cmovnz", enc(fpu32_pkg::OP_R2, fpu32_pkg::FN_CMOVNZ, 3'd7),
				(n < 3) ? 32'd0 : x, y, rand_bits(32), 32'd0);
		end
		close_test("compare_cmov");

		for (int f = 0; f < 7; f++) begin
			for (int n = 0; n < 12; n++) begin
				x = (n < 8) ? specials[n] : rand_bits(32);
				run_op("sign_class", enc(fpu32_pkg::OP_FLT, sgn_fns[f], 3'd0),
					x, rand_bits(32), 32'd0, 32'd0);
			end
		end
		close_test("sign_classify");

		for (int f = 0; f < 4; f++) begin
			for (int p = 0; p < 8; p++)
				for (int q = 0; q < 8; q++)
					run_op("fcmp", enc(fpu32_pkg::OP_FLT, cmp_fns[f], 3'd0),
						specials[p], specials[q], 32'd0, 32'd0);
			for (int n = 0; n < 8; n++)
				run_op("fcmp_rand", enc(fpu32_pkg::OP_FLT, cmp_fns[f], 3'd0),
					rand_bits(32), rand_bits(32), 32'd0, 32'd0);
		end
		close_test("float_compare");

		// Saturation edges around 2^31, NaN and infinity come before the random values
		for (int n = 0; n < 8; n++)
			run_op("ftoi_edge", enc(fpu32_pkg::OP_FLT, fpu32_pkg::FN_FTOI, 3'd0),
				specials[n], 32'd0, 32'd0, 32'd0);
		run_op("ftoi_edge", enc(fpu32_pkg::OP_FLT, fpu32_pkg::FN_FTOI, 3'd0),
			32'h4F00_0000, 32'd0, 32'd0, 32'd0);
		run_op("ftoi_edge", enc(fpu32_pkg::OP_FLT, fpu32_pkg::FN_FTOI, 3'd0),
			32'hCF00_0001, 32'd0, 32'd0, 32'd0);
		run_op("itof_edge", enc(fpu32_pkg::OP_FLT, fpu32_pkg::FN_ITOF, 3'd0),
			32'h8000_0000, 32'd0, 32'd0, 32'd0);
		run_op("itof_edge", enc(fpu32_pkg::OP_FLT, fpu32_pkg::FN_ITOF, 3'd0),
			32'h7FFF_FFFF, 32'd0, 32'd0, 32'd0);
		for (int n = 0; n < 16; n++) begin
			run_op("ftoi", enc(fpu32_pkg::OP_FLT, fpu32_pkg::FN_FTOI, 3'd0),
				{rand_bits(1), 3'b100, rand_bits(28)}, 32'd0, 32'd0, 32'd0);
			run_op("itof", enc(fpu32_pkg::OP_FLT, fpu32_pkg::FN_ITOF, 3'd0),
				rand_bits(32) >> rand_bits(5), 32'd0, 32'd0, 32'd0);
		end
		close_test("conversions");

		run_op("nop", enc(fpu32_pkg::OP_NOP, 6'd0, 3'd0), rand_bits(32), 32'd1, 32'd1, 32'd1);
		run_op("undef", enc(7'h55, 6'd0, 3'd0), rand_bits(32), 32'd1, 32'd1, 32'd1);
		// Moving a in the middle of a conversion makes run_op see the full latency again
		ir = enc(fpu32_pkg::OP_FLT, fpu32_pkg::FN_ITOF, 3'd0);
		a  = rand_bits(32);
		@(negedge clk);
		assert (!done)
		else begin
			$display("ERROR %0t: done high one cycle into a conversion", $time);
			test_fail++;
		end
		run_op("restart", ir, rand_bits(32), b, c, i);
		close_test("nop_restart");

		chk_fails = i_fpu32_unit.i_checker.fail_cnt;
		$display("tests passed %0d, tests failed %0d, checker failures %0d",
			tests_ok, tests_bad, chk_fails);
		if (tests_bad == 0 && chk_fails == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+verilog
verilog/fpu32_pkg.sv
verilog/fpu32_decode.sv
verilog/fpu32_int_exec.sv
verilog/fpu32_fp_exec.sv
verilog/fpu32_result.sv
verilog/fpu32_unit.sv
dv/fpu32_checker.sv
dv/fpu32_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= fpu32_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
